//--- s16_main_pkg.sv
////////////////////////////////////////
// System 16A main board shared types
// Bus widths, memory-map region tags
// and video timing constants
////////////////////////////////////////

package s16_main_pkg;

    typedef logic [23:1] cpu_addr_t;   // 68000 word address
    typedef logic [15:0] cpu_data_t;
    typedef logic [7:0]  byte_t;       // Port and switch value
    typedef logic [2:0]  fc_t;         // Function code
    typedef logic [8:0]  vdump_t;      // Vertical line counter

    // Line on which the VBLANK interrupt is raised
    localparam vdump_t VBLANK_LINE = 9'd223;

    // Interrupt acknowledge cycle
    localparam fc_t FC_INT_ACK = 3'd7;

    // Region tags decoded from address bits 23..16
    localparam logic [3:0] REGION_NONE = 4'd0;   // Unmapped gives a bus error
    localparam logic [3:0] REGION_ROM  = 4'd1;   // 00-03
    localparam logic [3:0] REGION_VRAM = 4'd2;   // 40
    localparam logic [3:0] REGION_CHAR = 4'd3;   // 41
    localparam logic [3:0] REGION_OBJ  = 4'd4;   // 44
    localparam logic [3:0] REGION_PAL  = 4'd5;   // 84
    localparam logic [3:0] REGION_IO   = 4'd6;   // c4
    localparam logic [3:0] REGION_RAM  = 4'd7;   // c7

    // Upper address bytes of the single-byte regions
    localparam logic [7:0] MAP_VRAM = 8'h40;
    localparam logic [7:0] MAP_CHAR = 8'h41;
    localparam logic [7:0] MAP_OBJ  = 8'h44;
    localparam logic [7:0] MAP_PAL  = 8'h84;
    localparam logic [7:0] MAP_IO   = 8'hc4;
    localparam logic [7:0] MAP_RAM  = 8'hc7;

endpackage

//--- s16_bus_ctrl.sv
////////////////////////////////////////
// 68000 bus control
// Memory-map decoder, registered chip
// selects, bus error and read-data mux
////////////////////////////////////////

`timescale 1ns/1ps

module s16_bus_ctrl import s16_main_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  cpu_addr_t addr,
    input  logic      as_n,
    input  logic      uds_n,
    input  logic      lds_n,
    input  cpu_data_t rom_data,
    input  cpu_data_t ram_data,
    input  cpu_data_t char_dout,
    input  cpu_data_t pal_dout,
    input  cpu_data_t obj_dout,
    input  byte_t     cab_dout,
    input  logic      rom_ok,
    input  logic      ram_ok,
    output logic      rom_cs,
    output logic      ram_cs,
    output logic      vram_cs,
    output logic      char_cs,
    output logic      pal_cs,
    output logic      objram_cs,
    output logic      io_cs,
    output logic      berr_n,
    output logic      bus_cs,
    output logic      bus_busy,
    output cpu_data_t cpu_din
);

    logic [3:0] region;
    logic       data_strobe;
    logic       io_first;       // First cycle of an IO select

    function automatic logic [3:0] region_of(input cpu_addr_t a);
        logic [7:0] hi;
        hi = a[23:16];
        if (hi[7:2] == 6'd0)
            return REGION_ROM;  // 00-03
        case (hi)
            MAP_VRAM: return REGION_VRAM;
            MAP_CHAR: return REGION_CHAR;
            MAP_OBJ:  return REGION_OBJ;
            MAP_PAL:  return REGION_PAL;
            MAP_IO:   return REGION_IO;
            MAP_RAM:  return REGION_RAM;
            default:  return REGION_NONE;
        endcase
    endfunction

    assign region      = region_of(addr);
    assign data_strobe = !(uds_n && lds_n);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
            io_first  <= 1'b0;
            berr_n    <= 1'b1;
        end else begin
            io_first <= !as_n && region == REGION_IO && !io_cs;
            if (!as_n) begin
                rom_cs    <= region == REGION_ROM;
                char_cs   <= region == REGION_CHAR;
                objram_cs <= region == REGION_OBJ;
                pal_cs    <= region == REGION_PAL;
                io_cs     <= region == REGION_IO;
                // RAM requests wait for a data strobe
                vram_cs   <= region == REGION_VRAM && data_strobe;
                ram_cs    <= region == REGION_RAM && data_strobe;
                berr_n    <= region != REGION_NONE;
            end else begin
                rom_cs    <= 1'b0;
                ram_cs    <= 1'b0;
                vram_cs   <= 1'b0;
                char_cs   <= 1'b0;
                pal_cs    <= 1'b0;
                objram_cs <= 1'b0;
                io_cs     <= 1'b0;
                berr_n    <= 1'b1;
            end
        end
    end

    assign bus_cs = |{rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, io_cs};

    // IO data comes out of the cabinet register one clock late
    assign bus_busy = (rom_cs && !rom_ok) || ((ram_cs || vram_cs) && !ram_ok) || io_first;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= 16'hffff;
        end else if (ram_cs || vram_cs) begin
            cpu_din <= ram_data;
        end else if (rom_cs) begin
            cpu_din <= rom_data;    // No decryption
        end else if (char_cs) begin
            cpu_din <= char_dout;
        end else if (pal_cs) begin
            cpu_din <= pal_dout;
        end else if (objram_cs) begin
            cpu_din <= obj_dout;
        end else if (io_cs) begin
            cpu_din <= {8'hff, cab_dout};
        end else begin
            cpu_din <= 16'hffff;    // Open bus
        end
    end

endmodule

//--- s16_cab_io.sv
////////////////////////////////////////
// Cabinet IO block
// Joystick, coin and DIP switch reads
// plus the 8255 access strobes
////////////////////////////////////////

`timescale 1ns/1ps

module s16_cab_io import s16_main_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       io_cs,
    input  cpu_addr_t  addr,
    input  logic       rnw,
    input  logic       lds_n,
    input  cpu_data_t  cpu_dout,
    input  byte_t      ppi_dout,
    input  byte_t      joystick1,
    input  byte_t      joystick2,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic       service,
    input  logic       dip_test,
    input  byte_t      dipsw_a,
    input  byte_t      dipsw_b,
    output byte_t      cab_dout,
    output logic       ppi_we,
    output logic [1:0] ppi_addr,
    output byte_t      ppi_din
);

    logic io_cs_q;

    // Board wiring of the joystick lines
    function automatic byte_t sort_joy(input byte_t joy);
        return {joy[1:0], joy[3:2], joy[7], joy[5:4], joy[6]};
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            io_cs_q  <= 1'b0;
            cab_dout <= 8'hff;
        end else begin
            io_cs_q  <= io_cs;
            cab_dout <= 8'hff;
            if (io_cs) begin
                case (addr[13:12])
                    2'd0: cab_dout <= ppi_dout;
                    2'd1: begin
                        case (addr[2:1])
                            2'd0: cab_dout <= {2'b11, start_button, service, dip_test,
                                               coin_input};
                            2'd1: cab_dout <= sort_joy(joystick1);
                            2'd3: cab_dout <= sort_joy(joystick2);
                            default: cab_dout <= 8'hff;
                        endcase
                    end
                    2'd2: cab_dout <= addr[1] ? dipsw_b : dipsw_a;
                    default: cab_dout <= 8'hff;
                endcase
            end
        end
    end

    // One strobe per access on the lower byte
    assign ppi_we   = io_cs && !io_cs_q && !rnw && !lds_n && addr[13:12] == 2'd0;
    assign ppi_addr = addr[2:1];
    assign ppi_din  = cpu_dout[7:0];

endmodule

//--- s16_ppi.sv
////////////////////////////////////////
// Simplified 8255 parallel port
// Three output latches, mode write and
// port C bit set/reset
////////////////////////////////////////

`timescale 1ns/1ps

module s16_ppi import s16_main_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       ppi_we,
    input  logic [1:0] ppi_addr,
    input  byte_t      ppi_din,
    input  logic       snd_ack,
    output byte_t      ppi_dout,
    output byte_t      porta_out,
    output byte_t      portb_out,
    output byte_t      portc_out
);

    byte_t mode;    // Last mode word written

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            porta_out <= 8'hff;
            portb_out <= 8'hff;
            portc_out <= 8'hff;
            mode      <= 8'h9b;     // All ports as inputs
        end else if (ppi_we) begin
            case (ppi_addr)
                2'd0: porta_out <= ppi_din;
                2'd1: portb_out <= ppi_din;
                2'd2: begin
                    // Bit 6 is the sound acknowledge input
                    portc_out[7]   <= ppi_din[7];
                    portc_out[5:0] <= ppi_din[5:0];
                end
                default: begin
                    if (ppi_din[7]) begin
                        // Mode set clears every output latch
                        mode      <= ppi_din;
                        porta_out <= 8'h00;
                        portb_out <= 8'h00;
                        portc_out <= 8'h00;
                    end else begin
                        portc_out[ppi_din[3:1]] <= ppi_din[0];
                    end
                end
            endcase
        end
    end

    always_comb begin
        case (ppi_addr)
            2'd0: ppi_dout = porta_out;
            2'd1: ppi_dout = portb_out;
            2'd2: ppi_dout = {portc_out[7], snd_ack, portc_out[5:0]};
            default: ppi_dout = mode;
        endcase
    end

endmodule

//--- s16_dtack.sv
////////////////////////////////////////
// CPU clock enable and DTACK generator
// Fractional cen/cenb pair and wait
// states driven by the bus busy flag
////////////////////////////////////////

`timescale 1ns/1ps

module s16_dtack #(
    parameter int CEN_NUM = 29,     // Keep 2*CEN_NUM <= CEN_DEN
    parameter int CEN_DEN = 146
) (
    input  logic clk,
    input  logic rst,
    input  logic bus_cs,
    input  logic bus_busy,
    input  logic as_n,
    output logic cpu_cen,
    output logic cpu_cenb,
    output logic dtack_n
);

    localparam int W    = $clog2(CEN_DEN + CEN_NUM) + 1;
    localparam int HALF = CEN_DEN / 2;

    typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_ACKED} state_t;

    state_t         state;
    logic [W-1:0]   acc;
    logic [W-1:0]   acc_sum;
    logic           ready;

    assign acc_sum = acc + W'(CEN_NUM);
    assign ready   = cpu_cenb && bus_cs && !bus_busy;

    // cen on overflow, cenb when the phase crosses the half point
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc      <= '0;
            cpu_cen  <= 1'b0;
            cpu_cenb <= 1'b0;
        end else begin
            cpu_cen  <= acc_sum >= W'(CEN_DEN);
            cpu_cenb <= acc < W'(HALF) && acc_sum >= W'(HALF) && acc_sum < W'(CEN_DEN);
            acc      <= acc_sum >= W'(CEN_DEN) ? acc_sum - W'(CEN_DEN) : acc_sum;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ST_IDLE;
            dtack_n <= 1'b1;
        end else begin
            case (state)
                ST_IDLE, ST_WAIT: begin
                    if (as_n) begin
                        state <= ST_IDLE;
                    end else if (ready) begin
                        state   <= ST_ACKED;
                        dtack_n <= 1'b0;
                    end else begin
                        state <= ST_WAIT;   // Memory not ready yet
                    end
                end
                default: begin
                    if (as_n) begin
                        state   <= ST_IDLE;
                        dtack_n <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

//--- s16_vblank_irq.sv
////////////////////////////////////////
// VBLANK interrupt
// Raised on the VBLANK line, cleared
// by the CPU acknowledge cycle
////////////////////////////////////////

`timescale 1ns/1ps

module s16_vblank_irq import s16_main_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  vdump_t vdump,
    input  logic   hstart,
    input  logic   as_n,
    input  fc_t    fc,
    output logic   irq_n
);

    logic hstart_q;
    logic int_ack;

    assign int_ack = !as_n && fc == FC_INT_ACK;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hstart_q <= 1'b0;
            irq_n    <= 1'b1;
        end else begin
            hstart_q <= hstart;
            if (int_ack) begin
                irq_n <= 1'b1;
            end else if (hstart && !hstart_q && vdump == VBLANK_LINE) begin
                irq_n <= 1'b0;  // Start of VBLANK
            end
        end
    end

endmodule

//--- s16_main.sv
////////////////////////////////////////
// System 16A main board glue logic
// Bus control, cabinet IO, 8255 port,
// DTACK and VBLANK interrupt
////////////////////////////////////////

`timescale 1ns/1ps

module s16_main import s16_main_pkg::*; #(
    parameter int CEN_NUM = 29,
    parameter int CEN_DEN = 146
) (
    input  logic       clk,
    input  logic       rst,
    // 68000 bus
    input  cpu_addr_t  addr,
    input  logic       as_n,
    input  logic       uds_n,
    input  logic       lds_n,
    input  logic       rnw,
    input  fc_t        fc,
    input  cpu_data_t  cpu_dout,
    output cpu_data_t  cpu_din,
    output logic       dtack_n,
    output logic       berr_n,
    output logic       irq_n,
    output logic       cpu_cen,
    output logic       cpu_cenb,
    // Memories
    output logic       rom_cs,
    output logic       ram_cs,
    output logic       vram_cs,
    output logic       char_cs,
    output logic       pal_cs,
    output logic       objram_cs,
    input  cpu_data_t  rom_data,
    input  cpu_data_t  ram_data,
    input  cpu_data_t  char_dout,
    input  cpu_data_t  pal_dout,
    input  cpu_data_t  obj_dout,
    input  logic       rom_ok,
    input  logic       ram_ok,
    // Cabinet
    input  byte_t      joystick1,
    input  byte_t      joystick2,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic       service,
    input  logic       dip_test,
    input  byte_t      dipsw_a,
    input  byte_t      dipsw_b,
    // Sound and video control
    output byte_t      snd_latch,
    output logic       snd_irqn,
    input  logic       snd_ack,
    output logic       flip,
    output logic       colscr_en,
    output logic       rowscr_en,
    input  vdump_t     vdump,
    input  logic       hstart
);

    logic       io_cs, bus_cs, bus_busy, ppi_we;
    logic [1:0] ppi_addr;
    byte_t      cab_dout, ppi_din, ppi_dout, portb_out, portc_out;

    assign flip      = portb_out[7];
    assign snd_irqn  = portc_out[7];
    assign colscr_en = ~portc_out[2];
    assign rowscr_en = ~portc_out[1];

    s16_bus_ctrl u_bus_ctrl (
        .clk(clk), .rst(rst), .addr(addr), .as_n(as_n), .uds_n(uds_n), .lds_n(lds_n),
        .rom_data(rom_data), .ram_data(ram_data), .char_dout(char_dout),
        .pal_dout(pal_dout), .obj_dout(obj_dout), .cab_dout(cab_dout),
        .rom_ok(rom_ok), .ram_ok(ram_ok), .rom_cs(rom_cs), .ram_cs(ram_cs),
        .vram_cs(vram_cs), .char_cs(char_cs), .pal_cs(pal_cs), .objram_cs(objram_cs),
        .io_cs(io_cs), .berr_n(berr_n), .bus_cs(bus_cs), .bus_busy(bus_busy),
        .cpu_din(cpu_din)
    );

    s16_cab_io u_cab_io (
        .clk(clk), .rst(rst), .io_cs(io_cs), .addr(addr), .rnw(rnw), .lds_n(lds_n),
        .cpu_dout(cpu_dout), .ppi_dout(ppi_dout), .joystick1(joystick1),
        .joystick2(joystick2), .start_button(start_button), .coin_input(coin_input),
        .service(service), .dip_test(dip_test), .dipsw_a(dipsw_a), .dipsw_b(dipsw_b),
        .cab_dout(cab_dout), .ppi_we(ppi_we), .ppi_addr(ppi_addr), .ppi_din(ppi_din)
    );

    s16_ppi u_ppi (
        .clk(clk), .rst(rst), .ppi_we(ppi_we), .ppi_addr(ppi_addr), .ppi_din(ppi_din),
        .snd_ack(snd_ack), .ppi_dout(ppi_dout), .porta_out(snd_latch),
        .portb_out(portb_out), .portc_out(portc_out)
    );

    s16_dtack #(.CEN_NUM(CEN_NUM), .CEN_DEN(CEN_DEN)) u_dtack (
        .clk(clk), .rst(rst), .bus_cs(bus_cs), .bus_busy(bus_busy), .as_n(as_n),
        .cpu_cen(cpu_cen), .cpu_cenb(cpu_cenb), .dtack_n(dtack_n)
    );

    s16_vblank_irq u_vblank_irq (
        .clk(clk), .rst(rst), .vdump(vdump), .hstart(hstart), .as_n(as_n), .fc(fc),
        .irq_n(irq_n)
    );

endmodule

//--- s16_main_assert.sv
////////////////////////////////////////
// System 16A main board checks
// Decode, DTACK, VBLANK IRQ and CPU
// clock enable properties
////////////////////////////////////////

`timescale 1ns/1ps

module s16_main_checks import s16_main_pkg::*; #(
    parameter int CEN_NUM = 29,
    parameter int CEN_DEN = 146
) (
    input logic      clk,
    input logic      rst,
    input cpu_addr_t addr,
    input logic      as_n,
    input logic      uds_n,
    input logic      lds_n,
    input fc_t       fc,
    input logic      rom_cs,
    input logic      ram_cs,
    input logic      vram_cs,
    input logic      char_cs,
    input logic      pal_cs,
    input logic      objram_cs,
    input logic      rom_ok,
    input logic      ram_ok,
    input logic      berr_n,
    input logic      dtack_n,
    input logic      irq_n,
    input logic      cpu_cen,
    input logic      cpu_cenb,
    input vdump_t    vdump,
    input logic      hstart
);

    logic [5:0] sel;
    logic [5:0] sel_exp;
    logic [3:0] region;
    logic       strobe;
    logic       int_ack;
    logic       warm;       // Past the reset value of cpu_cen
    int         phase;
    int         cen_cnt;
    int         fail_count = 0;

    // System 16A map by upper address byte
    function automatic logic [3:0] map_region(input logic [7:0] hi);
        if (hi <= 8'h03)
            return REGION_ROM;
        case (hi)
            8'h40:   return REGION_VRAM;
            8'h41:   return REGION_CHAR;
            8'h44:   return REGION_OBJ;
            8'h84:   return REGION_PAL;
            8'hc4:   return REGION_IO;
            8'hc7:   return REGION_RAM;
            default: return REGION_NONE;
        endcase
    endfunction

    assign region  = map_region(addr[23:16]);
    assign strobe  = !uds_n || !lds_n;
    assign int_ack = !as_n && fc == FC_INT_ACK;
    assign sel     = {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_exp <= '0;
            warm    <= 1'b0;
            phase   <= 0;
            cen_cnt <= 0;
        end else begin
            warm <= 1'b1;
            if (as_n)
                sel_exp <= '0;
            else
                sel_exp <= {region == REGION_ROM, region == REGION_RAM && strobe,
                            region == REGION_VRAM && strobe, region == REGION_CHAR,
                            region == REGION_PAL, region == REGION_OBJ};
            if (warm) begin
                if (phase == CEN_DEN - 1) begin
                    phase   <= 0;
                    cen_cnt <= 0;
                end else begin
                    phase   <= phase + 1;
                    cen_cnt <= cen_cnt + int'(cpu_cen);
                end
            end
        end
    end

    a_decode: assert property (@(posedge clk) disable iff (rst) sel == sel_exp)
        else begin
            $error("chip selects %b, expected %b", sel, sel_exp);
            fail_count++;
        end

    a_berr: assert property (@(posedge clk) disable iff (rst)
        !as_n && region == REGION_NONE |=> !berr_n)
        else begin
            $error("unmapped access without bus error");
            fail_count++;
        end

    a_berr_no_dtack: assert property (@(posedge clk) disable iff (rst) !berr_n |-> dtack_n)
        else begin
            $error("dtack_n low during a bus error");
            fail_count++;
        end

    // No acknowledge ahead of the memory
    a_wait: assert property (@(posedge clk) disable iff (rst)
        $fell(dtack_n) |-> $past(rom_ok || !rom_cs) && $past(ram_ok || !(ram_cs || vram_cs)))
        else begin
            $error("dtack_n fell while the memory ok was low");
            fail_count++;
        end

    a_release: assert property (@(posedge clk) disable iff (rst) as_n && !dtack_n |=> dtack_n)
        else begin
            $error("dtack_n still low after as_n rose");
            fail_count++;
        end

    a_irq_set: assert property (@(posedge clk) disable iff (rst)
        $rose(hstart) && vdump == VBLANK_LINE && !int_ack |=> !irq_n)
        else begin
            $error("no interrupt on the VBLANK line");
            fail_count++;
        end

    a_irq_quiet: assert property (@(posedge clk) disable iff (rst)
        irq_n && !($rose(hstart) && vdump == VBLANK_LINE) |=> irq_n)
        else begin
            $error("interrupt raised outside the VBLANK line");
            fail_count++;
        end

    a_irq_hold: assert property (@(posedge clk) disable iff (rst) !irq_n && !int_ack |=> !irq_n)
        else begin
            $error("interrupt dropped before its acknowledge");
            fail_count++;
        end

    a_irq_ack: assert property (@(posedge clk) disable iff (rst) int_ack |=> irq_n)
        else begin
            $error("interrupt not cleared by the acknowledge cycle");
            fail_count++;
        end

    a_cen_excl: assert property (@(posedge clk) disable iff (rst) !(cpu_cen && cpu_cenb))
        else begin
            $error("cpu_cen and cpu_cenb high together");
            fail_count++;
        end

    a_cen_rate: assert property (@(posedge clk) disable iff (rst)
        warm && phase == CEN_DEN - 1 |-> cen_cnt + int'(cpu_cen) == CEN_NUM)
        else begin
            $error("cpu_cen count %0d in one window", cen_cnt + int'(cpu_cen));
            fail_count++;
        end

endmodule

bind s16_main s16_main_checks #(.CEN_NUM(CEN_NUM), .CEN_DEN(CEN_DEN)) u_checks (.*);

//--- tb_s16_main.sv
////////////////////////////////////////
// Testbench for the System 16A main
// board glue, acting as the 68000
////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    always #4 clk = ~clk;   // 8 ns period

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

module tb_s16_main import s16_main_pkg::*; ();

    localparam int CEN_NUM       = 2;
    localparam int CEN_DEN       = 7;
    localparam int N_ACCESS      = 34;     // Upper bound on the bus cycles below
    localparam int ACCESS_CYCLES = 24;     // Select, memory delay, cenb wait, release
    localparam int WATCHDOG_NS   = (10 + N_ACCESS * ACCESS_CYCLES + 60) * 8;

    localparam cpu_data_t ROM_SALT  = 16'h3c5a;
    localparam cpu_data_t RAM_SALT  = 16'h9e21;
    localparam cpu_data_t CHAR_SALT = 16'h0f0f;
    localparam cpu_data_t PAL_SALT  = 16'h7711;
    localparam cpu_data_t OBJ_SALT  = 16'hc3a6;

    logic       clk, rst;
    cpu_addr_t  addr;
    logic       as_n, uds_n, lds_n, rnw;
    fc_t        fc;
    cpu_data_t  cpu_dout, cpu_din;
    logic       dtack_n, berr_n, irq_n, cpu_cen, cpu_cenb;
    logic       rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs;
    cpu_data_t  rom_data, ram_data, char_dout, pal_dout, obj_dout;
    logic       rom_ok, ram_ok;
    byte_t      joystick1, joystick2, dipsw_a, dipsw_b, snd_latch;
    logic [1:0] start_button, coin_input;
    logic       service, dip_test, snd_irqn, snd_ack, flip, colscr_en, rowscr_en;
    vdump_t     vdump;
    logic       hstart;
    logic [1:0] rom_wait, ram_wait;
    cpu_addr_t  rom_addr [4];
    cpu_data_t  rd;
    logic       be;
    int         seed = 32'h833e_c033;

    tb_clk_gen u_clk_gen (.clk(clk), .rst(rst));

    s16_main #(.CEN_NUM(CEN_NUM), .CEN_DEN(CEN_DEN)) UUT (.*);

    // Memory contents depend on every address bit
    function automatic cpu_data_t mem_word(input cpu_addr_t a, input cpu_data_t salt);
        return {a[8:1], a[16:9]} ^ {a[23:17], 9'd0} ^ salt;
    endfunction

    function automatic cpu_addr_t io_addr(input logic [1:0] sel, input logic [1:0] word);
        return {8'hc4, 2'b00, sel, 9'd0, word};
    endfunction

    assign rom_data  = mem_word(addr, ROM_SALT);
    assign ram_data  = mem_word(addr, RAM_SALT);
    assign char_dout = mem_word(addr, CHAR_SALT);
    assign pal_dout  = mem_word(addr, PAL_SALT);
    assign obj_dout  = mem_word(addr, OBJ_SALT);

    // SDRAM style ok lines with a random delay
    always @(posedge clk) begin
        if (rom_cs) begin
            if (rom_wait == 2'd0)
                rom_ok <= 1'b1;
            else
                rom_wait <= rom_wait - 2'd1;
        end else begin
            rom_ok   <= 1'b0;
            rom_wait <= 2'($random(seed));
        end
        if (ram_cs || vram_cs) begin
            if (ram_wait == 2'd0)
                ram_ok <= 1'b1;
            else
                ram_wait <= ram_wait - 2'd1;
        end else begin
            ram_ok   <= 1'b0;
            ram_wait <= 2'($random(seed));
        end
    end

    task automatic check_equal(input string name, input cpu_data_t got, input cpu_data_t exp);
        if (got !== exp) begin
            $display("error: %s is %h, expected %h", name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // One 68000 cycle ended by dtack_n or berr_n
    task automatic bus_cycle(input cpu_addr_t a, input logic write, input cpu_data_t wdata,
                             input fc_t f, output cpu_data_t rdata, output logic berr);
        @(posedge clk);
        addr     <= a;
        rnw      <= !write;
        fc       <= f;
        cpu_dout <= wdata;
        as_n     <= 1'b0;
        uds_n    <= 1'b0;
        lds_n    <= 1'b0;
        do @(negedge clk); while (dtack_n && berr_n);
        rdata = cpu_din;
        berr  = !berr_n;
        @(posedge clk);
        as_n  <= 1'b1;
        uds_n <= 1'b1;
        lds_n <= 1'b1;
        rnw   <= 1'b1;
        do @(negedge clk); while (!dtack_n || !berr_n);
    endtask

    task automatic read_expect(input cpu_addr_t a, input cpu_data_t exp);
        cpu_data_t data;
        logic      err;
        bus_cycle(a, 1'b0, 16'h0000, 3'd5, data, err);
        check_equal("berr_n", 16'(!err), 16'h0001);
        check_equal("cpu_din", data, exp);
    endtask

    task automatic write_word(input cpu_addr_t a, input cpu_data_t d);
        cpu_data_t data;
        logic      err;
        bus_cycle(a, 1'b1, d, 3'd5, data, err);
    endtask

    task automatic hstart_pulse(input vdump_t line);
        @(posedge clk);
        vdump  <= line;
        hstart <= 1'b1;
        @(posedge clk);
        hstart <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    initial begin
        addr = '0;
        as_n = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        rnw = 1'b1;
        fc = 3'd0;
        cpu_dout = '0;
        rom_ok = 1'b0;
        ram_ok = 1'b0;
        rom_wait = 2'd0;
        ram_wait = 2'd0;
        vdump = '0;
        hstart = 1'b0;
        snd_ack = 1'b0;
        joystick1 = 8'($random(seed));
        joystick2 = 8'($random(seed));
        dipsw_a = 8'($random(seed));
        dipsw_b = 8'($random(seed));
        start_button = 2'($random(seed));
        coin_input = 2'($random(seed));
        service = 1'($random(seed));
        dip_test = 1'($random(seed));
        for (int i = 0; i < 4; i++)
            rom_addr[i] = {6'd0, 17'($random(seed))};
        while (rst) @(negedge clk);

        for (int i = 0; i < 4; i++)
            read_expect(rom_addr[i], mem_word(rom_addr[i], ROM_SALT));
        read_expect({8'hc7, 15'h1234}, mem_word({8'hc7, 15'h1234}, RAM_SALT));
        read_expect({8'hc7, 15'h7ffe}, mem_word({8'hc7, 15'h7ffe}, RAM_SALT));
        read_expect({8'h40, 15'h0abc}, mem_word({8'h40, 15'h0abc}, RAM_SALT));
        read_expect({8'h41, 15'h0321}, mem_word({8'h41, 15'h0321}, CHAR_SALT));
        read_expect({8'h44, 15'h0055}, mem_word({8'h44, 15'h0055}, OBJ_SALT));
        read_expect({8'h84, 15'h0777}, mem_word({8'h84, 15'h0777}, PAL_SALT));
        bus_cycle({8'h20, 15'h0000}, 1'b0, 16'h0000, 3'd5, rd, be);
        check_equal("berr_n", 16'(!be), 16'h0000);
        check_equal("cpu_din", rd, 16'hffff);

        // Cabinet inputs and DIP switches
        read_expect(io_addr(2'd1, 2'd0),
                    {8'hff, 2'b11, start_button, service, dip_test, coin_input});
        read_expect(io_addr(2'd1, 2'd1), {8'hff, joystick1[1:0], joystick1[3:2],
                    joystick1[7], joystick1[5:4], joystick1[6]});
        read_expect(io_addr(2'd1, 2'd3), {8'hff, joystick2[1:0], joystick2[3:2],
                    joystick2[7], joystick2[5:4], joystick2[6]});
        read_expect(io_addr(2'd2, 2'd0), {8'hff, dipsw_a});
        read_expect(io_addr(2'd2, 2'd1), {8'hff, dipsw_b});

        // 8255 ports
        write_word(io_addr(2'd0, 2'd0), 16'h00a5);
        check_equal("snd_latch", {8'h00, snd_latch}, 16'h00a5);
        read_expect(io_addr(2'd0, 2'd0), 16'hffa5);
        write_word(io_addr(2'd0, 2'd1), 16'h0000);
        check_equal("flip", 16'(flip), 16'h0000);
        write_word(io_addr(2'd0, 2'd1), 16'h0080);
        check_equal("flip", 16'(flip), 16'h0001);
        write_word(io_addr(2'd0, 2'd3), 16'h000e);
        check_equal("snd_irqn", 16'(snd_irqn), 16'h0000);
        write_word(io_addr(2'd0, 2'd3), 16'h000f);
        check_equal("snd_irqn", 16'(snd_irqn), 16'h0001);
        write_word(io_addr(2'd0, 2'd3), 16'h0004);
        check_equal("colscr_en", 16'(colscr_en), 16'h0001);
        write_word(io_addr(2'd0, 2'd3), 16'h0005);
        check_equal("colscr_en", 16'(colscr_en), 16'h0000);
        write_word(io_addr(2'd0, 2'd3), 16'h0002);
        check_equal("rowscr_en", 16'(rowscr_en), 16'h0001);
        write_word(io_addr(2'd0, 2'd3), 16'h0003);
        check_equal("rowscr_en", 16'(rowscr_en), 16'h0000);
        for (int k = 0; k < 2; k++) begin
            @(posedge clk);
            snd_ack <= k[0];
            bus_cycle(io_addr(2'd0, 2'd2), 1'b0, 16'h0000, 3'd5, rd, be);
            check_equal("cpu_din[6]", 16'(rd[6]), 16'(k[0]));
        end

        // VBLANK interrupt and its acknowledge
        hstart_pulse(9'd100);
        check_equal("irq_n", 16'(irq_n), 16'h0001);
        hstart_pulse(VBLANK_LINE);
        check_equal("irq_n", 16'(irq_n), 16'h0000);
        bus_cycle({23{1'b1}}, 1'b0, 16'h0000, FC_INT_ACK, rd, be);
        check_equal("irq_n", 16'(irq_n), 16'h0001);

        repeat (2 * CEN_DEN) @(posedge clk);
        if (UUT.u_checks.fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "assertion checks reported errors");
        end
    end

    // Stop at the first failed assertion
    always @(negedge clk) begin
        if (UUT.u_checks.fail_count != 0) begin
            $display("an assertion on the DUT failed");
            $display("SOME TESTS FAILED");
            $fatal(1, "stopped at the first assertion error");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the DUT stopped answering bus cycles");
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- project.f
s16_main_pkg.sv
s16_bus_ctrl.sv
s16_cab_io.sv
s16_ppi.sv
s16_dtack.sv
s16_vblank_irq.sv
s16_main.sv
s16_main_assert.sv
tb_s16_main.sv

//--- Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_s16_main
FILELIST   = project.f
OBJ_DIR    = obj_dir
RUN_FLAGS  = +verilator+error+limit+100
PASS_MSG   = ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
